//--- run_sim.sh
#!/bin/sh
# build with Verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module sifh_tb -f sifh.f -o sifh_sim || exit 1
result=$(./obj_dir/sifh_sim +verilator+error+limit+100)
echo "$result"
echo "$result" | grep -qx "All tests passed" && exit 0 || exit 1

//--- sifh.f
verilog/sifh_pkg.sv
verilog/hist_bank.sv
verilog/frame_sequencer.sv
verilog/peak_picker.sv
verilog/sifh_top.sv
sim/sifh_clk_gen.sv
sim/sifh_checker.sv
sim/sifh_chk.sv
sim/sifh_tb.sv

//--- sim/sifh_checker.sv
module sifh_checker (
    input  logic             clk,
    input  logic             res,
    // result handshake seen at the DUT output
    input  logic             out_req,
    input  sifh_pkg::pixel_t out_pixel,
    input  sifh_pkg::bin_t   out_bin,
    input  sifh_pkg::count_t out_count,
    output logic             out_ack,
    // bank flag toggles once per frame
    input  logic             his_num
);

    // room for every expected record of the run
    localparam int MAX_REC = 256;

    // expected records filled by the model and read in arrival order
    int exp_pixel [MAX_REC];
    int exp_bin [MAX_REC];
    int exp_count [MAX_REC];
    int wr_idx = 0;
    int rd_idx = 0;

    // running event counts with a snapshot per test
    int mism_cnt = 0;
    int mism_base = 0;
    int toggles = 0;
    int toggle_base = 0;

    string test_name = "";
    int ack_delay = 0;
    int wait_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    logic his_prev = 1'b0;
    logic ack_r = 1'b0;

    assign out_ack = ack_r;

    task automatic start_test(input string name, input int delay);
        test_name = name;
        ack_delay = delay;
        mism_base = mism_cnt;
        toggle_base = toggles;
    endtask

    task automatic expect_record(input int pixel, input int bin, input int count);
        exp_pixel[wr_idx] = pixel;
        exp_bin[wr_idx] = bin;
        exp_count[wr_idx] = count;
        wr_idx++;
    endtask

    function automatic int records_left();
        return wr_idx - rd_idx;
    endfunction

    function automatic int failed_count();
        return fail_cnt;
    endfunction

    // one record is taken on the first cycle out_req is seen
    task automatic compare_record();
        string exp_s;
        string act_s;
        if (rd_idx >= wr_idx) begin
            $display("test %s: record for pixel %0d arrived with none pending",
                     test_name, out_pixel);
            mism_cnt++;
        end else begin
            if (out_pixel !== sifh_pkg::pixel_t'(exp_pixel[rd_idx])
                    || out_bin !== sifh_pkg::bin_t'(exp_bin[rd_idx])
                    || out_count !== sifh_pkg::count_t'(exp_count[rd_idx])) begin
                exp_s = $sformatf("pixel %0d bin %0d count %0d", exp_pixel[rd_idx],
                                  exp_bin[rd_idx], exp_count[rd_idx]);
                act_s = $sformatf("pixel %0d bin %0d count %0d", out_pixel,
                                  out_bin, out_count);
                $display("[FAIL] %s: expected %s, actual %s", test_name, exp_s, act_s);
                mism_cnt++;
            end
            rd_idx++;
        end
    endtask

    task automatic finish_test(input int frames);
        int errs;
        errs = mism_cnt - mism_base;
        if (wr_idx > rd_idx) begin
            $display("test %s: %0d expected records never arrived",
                     test_name, wr_idx - rd_idx);
            errs++;
        end
        if (toggles - toggle_base != frames) begin
            $display("test %s: his_num toggled %0d times over %0d frames",
                     test_name, toggles - toggle_base, frames);
            errs++;
        end
        if (errs == 0) begin
            pass_cnt++;
            $display("[PASS] %s", test_name);
        end else begin
            fail_cnt++;
            $display("test %s finished with %0d errors", test_name, errs);
        end
    endtask

    task automatic report();
        $display("%0d tests run, %0d passed, %0d failed",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    endtask

    // receiver side of the result handshake
    always @(posedge clk or negedge res) begin
        if (!res) begin
            ack_r <= 1'b0;
            wait_cnt <= 0;
            his_prev <= 1'b0;
        end else begin
            his_prev <= his_num;
            if (his_num != his_prev) begin
                toggles <= toggles + 1;
            end
            if (ack_r) begin
                // release once the DUT dropped its request
                if (!out_req) begin
                    ack_r <= 1'b0;
                end
            end else if (out_req) begin
                if (wait_cnt == 0) begin
                    compare_record();
                end
                // hold off ack for the test's delay
                if (wait_cnt >= ack_delay) begin
                    ack_r <= 1'b1;
                    wait_cnt <= 0;
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule

//--- sim/sifh_chk.sv
module sifh_chk (
    input logic             clk,
    input logic             res,
    input logic             in_req,
    input logic             in_ack,
    input logic             out_req,
    input logic             out_ack,
    input sifh_pkg::pixel_t out_pixel,
    input sifh_pkg::bin_t   out_bin,
    input sifh_pkg::count_t out_count
);

    // failure counts per rule
    int ack_fails = 0;
    int hold_fails = 0;
    int rise_fails = 0;

    function automatic int failures();
        return ack_fails + hold_fails + rise_fails;
    endfunction

    // in_ack only answers a request seen the cycle before
    ack_needs_req: assert property (@(posedge clk) disable iff (!res)
        $rose(in_ack) |-> $past(in_req))
    else begin
        $error("in_ack rose without in_req");
        ack_fails++;
    end

    // record fields frozen while the request stays up
    record_held: assert property (@(posedge clk) disable iff (!res)
        out_req && $past(out_req) |-> $stable(out_pixel) && $stable(out_bin) && $stable(out_count))
    else begin
        $error("out record changed while out_req high");
        hold_fails++;
    end

    // new record only after the receiver let go
    req_after_drop: assert property (@(posedge clk) disable iff (!res)
        $rose(out_req) |-> !$past(out_ack))
    else begin
        $error("out_req rose while out_ack high");
        rise_fails++;
    end

endmodule

bind sifh_top sifh_chk i_sifh_chk (.*);

//--- sim/sifh_clk_gen.sv
module sifh_clk_gen (
    output logic clk
);

    // half period of the 4 unit clock
    localparam int HALF_PERIOD = 2;

    // starts low, first rising edge at 2
    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

endmodule

//--- sim/sifh_tb.sv
module sifh_tb;

    localparam int N_TESTS = 6;
    localparam int FRAME_LEN = sifh_pkg::PIXEL_NUM * sifh_pkg::SAMPLE_NUM * sifh_pkg::ACQ_NUM;
    localparam int RESET_CYCLES = 5;
    // watchdog bounds, cycles per sample and per record
    localparam int SAMPLE_CYCLES = 8;
    localparam int RECORD_CYCLES = sifh_pkg::BIN_NUM + 12;
    localparam logic [31:0] SEED = 32'h7aed7781;

    // code patterns
    localparam int PAT_DISTINCT = 0;
    localparam int PAT_TIE = 1;
    localparam int PAT_SINGLE = 2;
    localparam int PAT_RANDOM = 3;

    // test table, name, frames sent back to back, pattern, out_ack delay
    string test_name [N_TESTS] = '{"distinct_peaks", "tie_low_bin", "concentrated",
                                   "two_frames", "back_pressure", "random_frames"};
    int test_frames [N_TESTS] = '{1, 1, 1, 2, 3, 2};
    int test_pattern [N_TESTS] = '{PAT_DISTINCT, PAT_TIE, PAT_SINGLE,
                                   PAT_DISTINCT, PAT_DISTINCT, PAT_RANDOM};
    int test_delay [N_TESTS] = '{1, 0, 2, 1, 60, 3};

    logic clk;
    logic res = 1'b0;
    logic in_req = 1'b0;
    sifh_pkg::bin_t in_bin = '0;
    logic in_ack;
    logic out_req;
    logic out_ack;
    sifh_pkg::pixel_t out_pixel;
    sifh_pkg::bin_t out_bin;
    sifh_pkg::count_t out_count;
    logic his_num;

    // codes of the frame being sent, in arrival order
    sifh_pkg::bin_t codes [FRAME_LEN];

    sifh_clk_gen i_clk_gen (.clk(clk));

    sifh_top i_sifh_top (
        .clk       (clk),
        .res       (res),
        .in_req    (in_req),
        .in_bin    (in_bin),
        .in_ack    (in_ack),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_pixel (out_pixel),
        .out_bin   (out_bin),
        .out_count (out_count),
        .his_num   (his_num)
    );

    sifh_checker i_checker (
        .clk       (clk),
        .res       (res),
        .out_req   (out_req),
        .out_pixel (out_pixel),
        .out_bin   (out_bin),
        .out_count (out_count),
        .out_ack   (out_ack),
        .his_num   (his_num)
    );

    // bin code of sample k in a frame
    function automatic sifh_pkg::bin_t make_code(input int pattern, input int frame, input int k);
        int s;
        int p;
        int a;
        int peak;
        s = k % sifh_pkg::SAMPLE_NUM;
        p = (k / sifh_pkg::SAMPLE_NUM) % sifh_pkg::PIXEL_NUM;
        a = k / (sifh_pkg::SAMPLE_NUM * sifh_pkg::PIXEL_NUM);
        // peak moves with the frame so stale counts would show
        peak = (p * 3 + frame * 5 + 1) % sifh_pkg::BIN_NUM;
        case (pattern)
            PAT_DISTINCT: begin
                // last sample of each acquisition lands off the peak
                if (s == sifh_pkg::SAMPLE_NUM - 1) begin
                    return sifh_pkg::bin_t'((peak + 1 + a) % sifh_pkg::BIN_NUM);
                end
                return sifh_pkg::bin_t'(peak);
            end
            // two bins share the samples evenly
            PAT_TIE: return sifh_pkg::bin_t'((s % 2 == 0) ? p + 10 : p + 3);
            PAT_SINGLE: return sifh_pkg::bin_t'((p * 4 + 3) % sifh_pkg::BIN_NUM);
            default: return sifh_pkg::bin_t'($urandom_range(sifh_pkg::BIN_NUM - 1, 0));
        endcase
    endfunction

    // reference model, histogram per pixel then lowest bin of the maximum
    task automatic expect_frame();
        int hist [sifh_pkg::PIXEL_NUM][sifh_pkg::BIN_NUM];
        int best_bin;
        int best_cnt;
        for (int p = 0; p < sifh_pkg::PIXEL_NUM; p++) begin
            for (int b = 0; b < sifh_pkg::BIN_NUM; b++) begin
                hist[p][b] = 0;
            end
        end
        for (int k = 0; k < FRAME_LEN; k++) begin
            hist[(k / sifh_pkg::SAMPLE_NUM) % sifh_pkg::PIXEL_NUM][codes[k]]++;
        end
        for (int p = 0; p < sifh_pkg::PIXEL_NUM; p++) begin
            best_bin = 0;
            best_cnt = hist[p][0];
            for (int b = 1; b < sifh_pkg::BIN_NUM; b++) begin
                if (hist[p][b] > best_cnt) begin
                    best_bin = b;
                    best_cnt = hist[p][b];
                end
            end
            i_checker.expect_record(p, best_bin, best_cnt);
        end
    endtask

    // one full four-phase cycle on the input, entered right after an edge
    task automatic send_sample(input sifh_pkg::bin_t code);
        in_bin <= code;
        in_req <= 1'b1;
        @(posedge clk);
        while (!in_ack) @(posedge clk);
        in_req <= 1'b0;
        @(posedge clk);
        while (in_ack) @(posedge clk);
    endtask

    initial begin
        int wait_cyc;
        int drain_limit;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        res <= 1'b1;
        @(posedge clk);
        for (int t = 0; t < N_TESTS; t++) begin
            i_checker.start_test(test_name[t], test_delay[t]);
            // all frames of a test go in without waiting for results
            for (int f = 0; f < test_frames[t]; f++) begin
                for (int k = 0; k < FRAME_LEN; k++) begin
                    codes[k] = make_code(test_pattern[t], f, k);
                end
                expect_frame();
                for (int k = 0; k < FRAME_LEN; k++) begin
                    send_sample(codes[k]);
                end
            end
            // wait for the picker to drain, bounded
            drain_limit = test_frames[t] * sifh_pkg::PIXEL_NUM * (RECORD_CYCLES + test_delay[t]);
            wait_cyc = 0;
            while ((i_checker.records_left() > 0 || out_req || out_ack)
                    && wait_cyc < drain_limit) begin
                @(posedge clk);
                wait_cyc++;
            end
            i_checker.finish_test(test_frames[t]);
        end
        i_checker.report();
        if (i_sifh_top.i_sifh_chk.failures() != 0) begin
            $display("%0d handshake assertions failed", i_sifh_top.i_sifh_chk.failures());
        end
        if (i_checker.failed_count() == 0 && i_sifh_top.i_sifh_chk.failures() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog, twice the summed sample and record bounds
    initial begin
        int limit;
        limit = RESET_CYCLES + 20;
        for (int t = 0; t < N_TESTS; t++) begin
            limit += test_frames[t] * (FRAME_LEN * SAMPLE_CYCLES
                     + sifh_pkg::PIXEL_NUM * (RECORD_CYCLES + test_delay[t]));
        end
        limit = 2 * limit;
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- verilog/frame_sequencer.sv
module frame_sequencer (
    input  logic             clk,
    input  logic             res,
    // four-phase sample input
    input  logic             in_req,
    input  sifh_pkg::bin_t   in_bin,
    output logic             in_ack,
    // increment strobes, one per bank
    output logic             inc_en_0,
    output logic             inc_en_1,
    output sifh_pkg::pixel_t inc_pixel,
    output sifh_pkg::bin_t   inc_bin,
    // bank currently filling
    output logic             his_num,
    // four-phase frame hand-off to the picker
    output logic             frame_req,
    output logic             frame_bank,
    input  logic             frame_ack
);

    sifh_pkg::seq_state_t  state;

    // nested position counters, sample inside pixel inside acquisition
    sifh_pkg::sample_idx_t sample_cnt;
    sifh_pkg::pixel_t      pixel_cnt;
    sifh_pkg::acq_idx_t    acq_cnt;

    logic accept;
    logic sample_wrap;
    logic pixel_wrap;
    logic acq_wrap;
    logic frame_last;
    logic handoff_free;

    // new request seen with ack low, and input not held
    assign accept = in_req && !in_ack && (state != sifh_pkg::STALL);

    assign sample_wrap = (sample_cnt == sifh_pkg::sample_idx_t'(sifh_pkg::SAMPLE_NUM - 1));
    assign pixel_wrap = (pixel_cnt == sifh_pkg::pixel_t'(sifh_pkg::PIXEL_NUM - 1));
    assign acq_wrap = (acq_cnt == sifh_pkg::acq_idx_t'(sifh_pkg::ACQ_NUM - 1));
    // sample now being taken closes the frame
    assign frame_last = sample_wrap && pixel_wrap && acq_wrap;

    // previous hand-off cycle fully done, both lines back low
    assign handoff_free = !frame_req && !frame_ack;

    // position counters
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sample_cnt <= '0;
            pixel_cnt <= '0;
            acq_cnt <= '0;
        end else if (accept) begin
            if (sample_wrap) begin
                sample_cnt <= '0;
                if (pixel_wrap) begin
                    pixel_cnt <= '0;
                    if (acq_wrap) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    // input ack and increment strobe
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            in_ack <= 1'b0;
            inc_en_0 <= 1'b0;
            inc_en_1 <= 1'b0;
        end else begin
            // strobe rises together with in_ack, old his_num picks the bank
            inc_en_0 <= accept && !his_num;
            inc_en_1 <= accept && his_num;
            if (accept) begin
                in_ack <= 1'b1;
            end else if (in_ack && !in_req) begin
                // source dropped req, close the handshake
                in_ack <= 1'b0;
            end
        end
    end

    // increment address, only meaningful with the strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            inc_pixel <= pixel_cnt;
            inc_bin <= in_bin;
        end
    end

    // bank selection and frame hand-off
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sifh_pkg::COLLECT;
            his_num <= 1'b0;
            frame_req <= 1'b0;
            frame_bank <= 1'b0;
        end else begin
            // swap banks on the last sample of every frame
            if (accept && frame_last) begin
                his_num <= !his_num;
            end
            // picker has finished the bank, release the request
            if (frame_req && frame_ack) begin
                frame_req <= 1'b0;
            end
            case (state)
                sifh_pkg::COLLECT: begin
                    // no readout pending, hand the bank over at once
                    if (accept && frame_last) begin
                        frame_req <= 1'b1;
                        frame_bank <= his_num;
                        state <= sifh_pkg::HANDOFF;
                    end
                end
                sifh_pkg::HANDOFF: begin
                    // next frame filled before the picker let go
                    if (accept && frame_last) begin
                        state <= sifh_pkg::STALL;
                    end else if (handoff_free) begin
                        state <= sifh_pkg::COLLECT;
                    end
                end
                sifh_pkg::STALL: begin
                    // his_num already points at the bank under readout,
                    // the waiting frame sits in the other one
                    if (handoff_free) begin
                        frame_req <= 1'b1;
                        frame_bank <= !his_num;
                        state <= sifh_pkg::HANDOFF;
                    end
                end
                default: begin
                    state <= sifh_pkg::COLLECT;
                end
            endcase
        end
    end

endmodule

//--- verilog/hist_bank.sv
module hist_bank (
    input  logic             clk,
    input  logic             res,
    // increment port, single-cycle strobe from the sequencer
    input  logic             inc_en,
    input  sifh_pkg::pixel_t inc_pixel,
    input  sifh_pkg::bin_t   inc_bin,
    // read-and-clear port from the peak picker
    input  logic             rd_en,
    input  sifh_pkg::pixel_t rd_pixel,
    input  sifh_pkg::bin_t   rd_bin,
    output sifh_pkg::count_t rd_data
);

    // counter array, one row per pixel, one column per time bin
    sifh_pkg::count_t cnt_mem [sifh_pkg::PIXEL_NUM][sifh_pkg::BIN_NUM];

    // counter update
    // increment and clear never address the same counter,
    // since the sequencer only fills the bank that is not being read
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // whole bank starts empty
            for (int p = 0; p < sifh_pkg::PIXEL_NUM; p++) begin
                for (int b = 0; b < sifh_pkg::BIN_NUM; b++) begin
                    cnt_mem[p][b] <= '0;
                end
            end
        end else begin
            // one photon landed in this bin
            if (inc_en) begin
                cnt_mem[inc_pixel][inc_bin] <= cnt_mem[inc_pixel][inc_bin]
                                               + sifh_pkg::count_t'(1);
            end
            // read empties the counter on the same edge
            if (rd_en) begin
                cnt_mem[rd_pixel][rd_bin] <= '0;
            end
        end
    end

    // read data, valid the cycle after rd_en
    // holds the old value while no read is issued
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= cnt_mem[rd_pixel][rd_bin];
        end
    end

endmodule

//--- verilog/peak_picker.sv
module peak_picker (
    input  logic             clk,
    input  logic             res,
    // four-phase frame hand-off from the sequencer
    input  logic             frame_req,
    input  logic             frame_bank,
    output logic             frame_ack,
    // read-and-clear ports to both banks
    output logic             rd_en_0,
    output logic             rd_en_1,
    output sifh_pkg::pixel_t rd_pixel,
    output sifh_pkg::bin_t   rd_bin,
    input  sifh_pkg::count_t rd_data_0,
    input  sifh_pkg::count_t rd_data_1,
    // four-phase result output
    output logic             out_req,
    input  logic             out_ack,
    output sifh_pkg::pixel_t out_pixel,
    output sifh_pkg::bin_t   out_bin,
    output sifh_pkg::count_t out_count
);

    sifh_pkg::pick_state_t state;

    // bank being scanned, latched at frame start
    logic cur_bank;
    // read issue side
    logic issuing;
    sifh_pkg::bin_t scan_bin;
    // read return side, one cycle behind
    logic data_vld;
    sifh_pkg::bin_t data_bin;
    sifh_pkg::count_t bank_data;

    logic scan_end;
    logic pixel_last;
    logic start_pixel;

    // selected bank return
    assign bank_data = cur_bank ? rd_data_1 : rd_data_0;

    // reads only happen while scanning, never while waiting on out_ack
    assign rd_en_0 = issuing && !cur_bank;
    assign rd_en_1 = issuing && cur_bank;
    assign rd_pixel = out_pixel;
    assign rd_bin = scan_bin;

    // last bin's data is coming back this cycle
    assign scan_end = data_vld && (data_bin == sifh_pkg::bin_t'(sifh_pkg::BIN_NUM - 1));
    assign pixel_last = (out_pixel == sifh_pkg::pixel_t'(sifh_pkg::PIXEL_NUM - 1));

    // new pixel scan begins, either first of frame or after a record
    assign start_pixel = ((state == sifh_pkg::IDLE) && frame_req)
                         || ((state == sifh_pkg::WAIT_DROP) && !out_ack && !pixel_last);

    // control FSM
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sifh_pkg::IDLE;
            cur_bank <= 1'b0;
            issuing <= 1'b0;
            scan_bin <= '0;
            data_vld <= 1'b0;
            out_pixel <= '0;
            out_req <= 1'b0;
            frame_ack <= 1'b0;
        end else begin
            data_vld <= issuing;
            // walk the bins, one read per cycle
            if (start_pixel) begin
                scan_bin <= '0;
                issuing <= 1'b1;
            end else if (issuing) begin
                if (scan_bin == sifh_pkg::bin_t'(sifh_pkg::BIN_NUM - 1)) begin
                    issuing <= 1'b0;
                end
                scan_bin <= scan_bin + 1'b1;
            end
            case (state)
                sifh_pkg::IDLE: begin
                    if (frame_req) begin
                        cur_bank <= frame_bank;
                        out_pixel <= '0;
                        state <= sifh_pkg::SCAN;
                    end
                end
                sifh_pkg::SCAN: begin
                    // running max is complete after this edge
                    if (scan_end) begin
                        out_req <= 1'b1;
                        state <= sifh_pkg::SEND;
                    end
                end
                sifh_pkg::SEND: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state <= sifh_pkg::WAIT_DROP;
                    end
                end
                sifh_pkg::WAIT_DROP: begin
                    // next record only once the receiver has let go
                    if (!out_ack) begin
                        if (pixel_last) begin
                            frame_ack <= 1'b1;
                            state <= sifh_pkg::DONE;
                        end else begin
                            out_pixel <= out_pixel + 1'b1;
                            state <= sifh_pkg::SCAN;
                        end
                    end
                end
                sifh_pkg::DONE: begin
                    // bank is empty again, finish the frame handshake
                    if (!frame_req) begin
                        frame_ack <= 1'b0;
                        state <= sifh_pkg::IDLE;
                    end
                end
                default: begin
                    state <= sifh_pkg::IDLE;
                end
            endcase
        end
    end

    // running maximum per pixel
    always_ff @(posedge clk) begin
        data_bin <= scan_bin;
        if (start_pixel) begin
            out_bin <= '0;
            out_count <= '0;
        end else if (data_vld && (bank_data > out_count)) begin
            // strictly greater only, so ties keep the lower bin
            out_bin <= data_bin;
            out_count <= bank_data;
        end
    end

endmodule

//--- verilog/sifh_pkg.sv
package sifh_pkg;

    // histogram geometry
    localparam int BIN_NUM = 16;
    localparam int BIN_W = 4;
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_W = 2;

    // acquisition pattern, sample is the inner loop, acquisition the outer
    localparam int SAMPLE_NUM = 4;
    localparam int SAMPLE_W = 2;
    localparam int ACQ_NUM = 3;
    localparam int ACQ_W = 2;

    // max count per bin is SAMPLE_NUM * ACQ_NUM, far below 2**COUNT_W
    localparam int COUNT_W = 8;

    // time-bin code from the pixel front end
    typedef logic [BIN_W-1:0] bin_t;
    // pixel index inside the array
    typedef logic [PIXEL_W-1:0] pixel_t;
    // one histogram counter
    typedef logic [COUNT_W-1:0] count_t;
    // sample index within one pixel
    typedef logic [SAMPLE_W-1:0] sample_idx_t;
    // acquisition index within one frame
    typedef logic [ACQ_W-1:0] acq_idx_t;

    // frame sequencer states
    typedef enum logic [1:0] {
        COLLECT,
        HANDOFF,
        STALL
    } seq_state_t;

    // peak picker states
    typedef enum logic [2:0] {
        IDLE,
        SCAN,
        SEND,
        WAIT_DROP,
        DONE
    } pick_state_t;

endpackage

//--- verilog/sifh_top.sv
module sifh_top (
    input  logic             clk,
    input  logic             res,
    // sample input
    input  logic             in_req,
    input  sifh_pkg::bin_t   in_bin,
    output logic             in_ack,
    // peak records
    output logic             out_req,
    input  logic             out_ack,
    output sifh_pkg::pixel_t out_pixel,
    output sifh_pkg::bin_t   out_bin,
    output sifh_pkg::count_t out_count,
    // bank currently filling
    output logic             his_num
);

    // increment path
    logic inc_en_0;
    logic inc_en_1;
    sifh_pkg::pixel_t inc_pixel;
    sifh_pkg::bin_t inc_bin;

    // frame hand-off
    logic frame_req;
    logic frame_ack;
    logic frame_bank;

    // read path
    logic rd_en_0;
    logic rd_en_1;
    sifh_pkg::pixel_t rd_pixel;
    sifh_pkg::bin_t rd_bin;
    sifh_pkg::count_t rd_data_0;
    sifh_pkg::count_t rd_data_1;

    // counts samples and picks the filling bank
    frame_sequencer i_frame_sequencer (
        .clk        (clk),
        .res        (res),
        .in_req     (in_req),
        .in_bin     (in_bin),
        .in_ack     (in_ack),
        .inc_en_0   (inc_en_0),
        .inc_en_1   (inc_en_1),
        .inc_pixel  (inc_pixel),
        .inc_bin    (inc_bin),
        .his_num    (his_num),
        .frame_req  (frame_req),
        .frame_bank (frame_bank),
        .frame_ack  (frame_ack)
    );

    // ping bank
    hist_bank i_bank_0 (
        .clk       (clk),
        .res       (res),
        .inc_en    (inc_en_0),
        .inc_pixel (inc_pixel),
        .inc_bin   (inc_bin),
        .rd_en     (rd_en_0),
        .rd_pixel  (rd_pixel),
        .rd_bin    (rd_bin),
        .rd_data   (rd_data_0)
    );

    // pong bank
    hist_bank i_bank_1 (
        .clk       (clk),
        .res       (res),
        .inc_en    (inc_en_1),
        .inc_pixel (inc_pixel),
        .inc_bin   (inc_bin),
        .rd_en     (rd_en_1),
        .rd_pixel  (rd_pixel),
        .rd_bin    (rd_bin),
        .rd_data   (rd_data_1)
    );

    // reads out the finished bank and sends one record per pixel
    peak_picker i_peak_picker (
        .clk        (clk),
        .res        (res),
        .frame_req  (frame_req),
        .frame_bank (frame_bank),
        .frame_ack  (frame_ack),
        .rd_en_0    (rd_en_0),
        .rd_en_1    (rd_en_1),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_data_0  (rd_data_0),
        .rd_data_1  (rd_data_1),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count)
    );

endmodule
